/* bench/dll_tx_tb.sv */
`timescale 1ns/10ps

module dll_tx_tb;

  logic                  clk_i;
  logic                  rst_i;
  dll_tx_pkg::dword_t    s_tdata_i;
  logic                  s_tlast_i;
  logic                  s_tvalid_i;
  logic                  s_tready_o;
  dll_tx_pkg::tx_beat_t  m_beat_o;
  logic                  m_tvalid_o;
  logic                  m_tready_i;
  dll_tx_pkg::fc_limit_t fc_limit_i;
  logic                  frame_done_o;
  dll_tx_pkg::seq_num_t  tx_seq_o;

  logic [31:0]          lfsr = 32'h6e590d93;
  string                test_name = "reset";
  logic                 stall_on = 1'b0;
  dll_tx_pkg::dword_t   tlp_q[$];
  dll_tx_pkg::tx_beat_t exp_q[$];
  logic [11:0]          exp_seq = '0;
  int                   frames_sent = 0;
  int                   done_count = 0;
  int                   posted_sent = 0;

  tb_clk_gen u_clk (.clk_o(clk_i));

  dll_tx_top dll_tx_top_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .s_tdata_i(s_tdata_i), .s_tlast_i(s_tlast_i),
    .s_tvalid_i(s_tvalid_i), .s_tready_o(s_tready_o),
    .m_beat_o(m_beat_o), .m_tvalid_o(m_tvalid_o), .m_tready_i(m_tready_i),
    .fc_limit_i(fc_limit_i), .frame_done_o(frame_done_o), .tx_seq_o(tx_seq_o)
  );

  task automatic value_error(input logic [63:0] exp, input logic [63:0] act);
    $display("** Error [%s] expected %h actual %h", test_name, exp, act);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic plain_error(input string msg);
    $display("[%s] %s", test_name, msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      c = (c[0] ^ b[i]) ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
    end
    return c;
  endfunction

  // reference frame: seq bytes, tlp bytes, lcrc lsb first
  task automatic queue_frame();
    logic [7:0]           bytes[$];
    logic [31:0]          crc;
    dll_tx_pkg::tx_beat_t beat;
    int                   k;
    bytes.push_back({4'h0, exp_seq[11:8]});
    bytes.push_back(exp_seq[7:0]);
    foreach (tlp_q[i]) begin
      for (int b = 0; b < 4; b++) bytes.push_back(tlp_q[i][8*b +: 8]);
    end
    crc = 32'hFFFFFFFF;
    foreach (bytes[i]) crc = crc_byte(crc, bytes[i]);
    crc = ~crc;
    for (int b = 0; b < 4; b++) bytes.push_back(crc[8*b +: 8]);
    for (int i = 0; i < bytes.size(); i += 4) begin
      beat = '0;
      k = bytes.size() - i;
      for (int b = 0; b < 4 && b < k; b++) begin
        beat.data[8*b +: 8] = bytes[i+b];
        beat.keep[b] = 1'b1;
      end
      beat.last = (k <= 4);
      exp_q.push_back(beat);
    end
    exp_seq = exp_seq + 12'd1;
    frames_sent++;
  endtask

  task automatic make_tlp(input logic [7:0] b0, input int len, input int n_data);
    tlp_q.delete();
    tlp_q.push_back({len[7:0], 6'b0, len[9:8], 8'h00, b0});
    tlp_q.push_back(rand_bits(32));
    tlp_q.push_back(rand_bits(32));
    for (int i = 0; i < n_data; i++) tlp_q.push_back(rand_bits(32));
  endtask

  task automatic send_tlp();
    int   t;
    logic took;
    queue_frame();
    foreach (tlp_q[i]) begin
      s_tdata_i  = tlp_q[i];
      s_tlast_i  = (i == tlp_q.size() - 1);
      s_tvalid_i = 1'b1;
      t = 0;
      do begin
        // ready has settled by mid-cycle
        @(negedge clk_i);
        took = s_tready_o;
        @(posedge clk_i);
        t++;
        if (!took && t > 1000) plain_error("input beat was never accepted");
      end while (!took);
      #1;
    end
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      t++;
      if (t > 2000) plain_error("expected beats never arrived");
    end
    repeat (2) @(posedge clk_i);
    assert (done_count == frames_sent) else value_error(frames_sent, done_count);
    assert (tx_seq_o == exp_seq) else value_error(exp_seq, tx_seq_o);
    #1;
  endtask

  // transfer completes at the next rising edge
  always @(negedge clk_i) begin
    if (!rst_i && m_tvalid_o && m_tready_i) begin
      if (exp_q.size() == 0) begin
        plain_error("output beat arrived with none expected");
      end else begin
        assert (m_beat_o == exp_q[0]) else value_error(exp_q[0], m_beat_o);
        void'(exp_q.pop_front());
      end
    end
    if (!rst_i && frame_done_o) done_count++;
  end

  // ready is random only while stalls are enabled
  always @(posedge clk_i) begin
    #1;
    m_tready_i = stall_on ? (rand_bits(2) != 0) : 1'b1;
  end

  a_seq_step: assert property (@(posedge clk_i) disable iff (rst_i)
    frame_done_o |=> tx_seq_o == dll_tx_pkg::seq_num_t'($past(tx_seq_o) + 12'd1))
    else plain_error("tx_seq_o did not advance after frame_done_o");

  initial begin
    rst_i      = 1'b1;
    s_tdata_i  = '0;
    s_tlast_i  = 1'b0;
    s_tvalid_i = 1'b0;
    m_tready_i = 1'b1;
    fc_limit_i = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    assert (tx_seq_o == 12'd0) else value_error(0, tx_seq_o);
    assert (!m_tvalid_o && !frame_done_o) else plain_error("outputs active after reset");

    // completion with zero credit room
    test_name = "cpl_no_credit";
    make_tlp(8'h4A, 2, 2);
    send_tlp();
    wait_drain();

    fc_limit_i.ph  = 8'hFF;
    fc_limit_i.pd  = 12'hFFF;
    fc_limit_i.nph = 8'hFF;
    fc_limit_i.npd = 12'hFFF;
    test_name = "np_read";
    make_tlp(8'h00, 1, 0);
    send_tlp();
    wait_drain();

    test_name = "write_cpl_random";
    for (int i = 0; i < 8; i++) begin
      make_tlp((i % 2 == 0) ? 8'h40 : 8'h4A, 0, 0);
      make_tlp(tlp_q[0][7:0], int'(rand_bits(3)) + 1, 0);
      for (int d = 0; d < int'(tlp_q[0][31:24]); d++) tlp_q.push_back(rand_bits(32));
      if (i % 2 == 0) posted_sent++;
      send_tlp();
    end
    wait_drain();

    test_name = "stalls";
    stall_on = 1'b1;
    for (int i = 0; i < 8; i++) begin
      make_tlp(8'h40, 5, 0);
      for (int d = 0; d < 5; d++) tlp_q.push_back(rand_bits(32));
      posted_sent++;
      send_tlp();
    end
    wait_drain();
    stall_on = 1'b0;

    // room for exactly one posted header
    test_name = "ph_gate";
    fc_limit_i.ph = 8'(posted_sent + 1);
    make_tlp(8'h40, 1, 1);
    posted_sent++;
    send_tlp();
    wait_drain();
    make_tlp(8'h40, 2, 2);
    fork
      send_tlp();
      begin
        repeat (200) begin
          @(posedge clk_i);
          assert (!m_tvalid_o) else plain_error("posted write passed without credit");
        end
        #1;
        fc_limit_i.ph = 8'(posted_sent + 1);
      end
    join
    wait_drain();

    if (exp_q.size() == 0 && done_count == frames_sent) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* bench/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
  end

  always #4 clk_o = ~clk_o;

endmodule

/* files.f */
+incdir+logic
logic/dll_tx_pkg.sv
logic/tlp_hdr_decode.sv
logic/fc_credit_ledger.sv
logic/lcrc32_engine.sv
logic/seq_lcrc_framer.sv
logic/tx_out_skid.sv
logic/dll_tx_top.sv
bench/tb_clk_gen.sv
bench/dll_tx_tb.sv

/* logic/dll_tx_defines.svh */
`ifndef DLL_TX_DEFINES_SVH
`define DLL_TX_DEFINES_SVH

// stream width, fixed
`define DLL_DATA_W 32

// one enable per byte lane
`define DLL_KEEP_W 4

// link sequence number
`define DLL_SEQ_W 12

// credit counter widths, as in the FC update DLLPs
`define DLL_HDR_CRED_W 8
`define DLL_DATA_CRED_W 12

// reflected crc-32
`define DLL_LCRC_INIT 32'hFFFF_FFFF
`define DLL_LCRC_POLY 32'hEDB8_8320

`endif

/* logic/dll_tx_pkg.sv */
package dll_tx_pkg;

  `include "dll_tx_defines.svh"

  typedef logic [`DLL_DATA_W-1:0] dword_t;
  typedef logic [`DLL_KEEP_W-1:0] keep_t;
  typedef logic [`DLL_SEQ_W-1:0] seq_num_t;
  typedef logic [`DLL_HDR_CRED_W-1:0] hdr_cred_t;
  typedef logic [`DLL_DATA_CRED_W-1:0] data_cred_t;
  typedef logic [31:0] lcrc_t;

  // flow control class of a tlp
  typedef enum logic [1:0] {
    TLP_POSTED,
    TLP_NON_POSTED,
    TLP_COMPLETION
  } tlp_class_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STREAM,
    ST_CRC_TAIL,
    ST_CRC_LAST
  } framer_state_e;

  // one beat towards the phy side
  typedef struct packed {
    dword_t data;
    keep_t  keep;
    logic   last;
  } tx_beat_t;

  // credit limits advertised by the link partner
  typedef struct packed {
    hdr_cred_t  ph;
    data_cred_t pd;
    hdr_cred_t  nph;
    data_cred_t npd;
  } fc_limit_t;

  typedef struct packed {
    tlp_class_e tlp_class;
    hdr_cred_t  hdr_need;
    data_cred_t data_need;
  } credit_req_t;

endpackage

/* logic/dll_tx_top.sv */
`timescale 1ns/10ps

module dll_tx_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // tlp stream in
  input  dll_tx_pkg::dword_t     s_tdata_i,
  input  logic                   s_tlast_i,
  input  logic                   s_tvalid_i,
  output logic                   s_tready_o,
  // framed stream out
  output dll_tx_pkg::tx_beat_t   m_beat_o,
  output logic                   m_tvalid_o,
  input  logic                   m_tready_i,
  input  dll_tx_pkg::fc_limit_t  fc_limit_i,
  output logic                   frame_done_o,
  output dll_tx_pkg::seq_num_t   tx_seq_o
);

  dll_tx_pkg::credit_req_t credit_req;
  logic                    start_grant;
  logic                    hdr_commit;
  dll_tx_pkg::tx_beat_t    frm_beat;
  logic                    frm_valid;
  logic                    frm_ready;

  // header dword 0 sits on the input bus while idle
  tlp_hdr_decode u_decode (
    .hdr_i (s_tdata_i),
    .req_o (credit_req)
  );

  fc_credit_ledger u_ledger (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .limit_i       (fc_limit_i),
    .req_i         (credit_req),
    .hdr_commit_i  (hdr_commit),
    .start_grant_o (start_grant)
  );

  seq_lcrc_framer u_framer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .s_tdata_i     (s_tdata_i),
    .s_tlast_i     (s_tlast_i),
    .s_tvalid_i    (s_tvalid_i),
    .s_tready_o    (s_tready_o),
    .start_grant_i (start_grant),
    .hdr_commit_o  (hdr_commit),
    .out_beat_o    (frm_beat),
    .out_valid_o   (frm_valid),
    .out_ready_i   (frm_ready),
    .frame_done_o  (frame_done_o),
    .tx_seq_o      (tx_seq_o)
  );

  tx_out_skid u_skid (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_beat_i   (frm_beat),
    .in_valid_i  (frm_valid),
    .in_ready_o  (frm_ready),
    .out_beat_o  (m_beat_o),
    .out_valid_o (m_tvalid_o),
    .out_ready_i (m_tready_i)
  );

endmodule

/* logic/fc_credit_ledger.sv */
`timescale 1ns/10ps

module fc_credit_ledger (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  dll_tx_pkg::fc_limit_t   limit_i,
  input  dll_tx_pkg::credit_req_t req_i,
  input  logic                    hdr_commit_i,
  output logic                    start_grant_o
);

  dll_tx_pkg::hdr_cred_t  ph_used_q;
  dll_tx_pkg::hdr_cred_t  nph_used_q;
  dll_tx_pkg::data_cred_t pd_used_q;
  dll_tx_pkg::data_cred_t npd_used_q;

  dll_tx_pkg::hdr_cred_t  ph_room;
  dll_tx_pkg::hdr_cred_t  nph_room;
  dll_tx_pkg::data_cred_t pd_room;
  dll_tx_pkg::data_cred_t npd_room;

  // modulo counter width
  assign ph_room  = limit_i.ph - ph_used_q;
  assign pd_room  = limit_i.pd - pd_used_q;
  assign nph_room = limit_i.nph - nph_used_q;
  assign npd_room = limit_i.npd - npd_used_q;

  always_comb begin
    case (req_i.tlp_class)
      dll_tx_pkg::TLP_POSTED:
        start_grant_o = (ph_room >= req_i.hdr_need) && (pd_room >= req_i.data_need);
      dll_tx_pkg::TLP_NON_POSTED:
        start_grant_o = (nph_room >= req_i.hdr_need) && (npd_room >= req_i.data_need);
      // completions have infinite credit
      default:
        start_grant_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ph_used_q  <= '0;
      pd_used_q  <= '0;
      nph_used_q <= '0;
      npd_used_q <= '0;
    end else if (hdr_commit_i) begin
      if (req_i.tlp_class == dll_tx_pkg::TLP_POSTED) begin
        ph_used_q <= ph_used_q + req_i.hdr_need;
        pd_used_q <= pd_used_q + req_i.data_need;
      end else if (req_i.tlp_class == dll_tx_pkg::TLP_NON_POSTED) begin
        nph_used_q <= nph_used_q + req_i.hdr_need;
        npd_used_q <= npd_used_q + req_i.data_need;
      end
    end
  end

  // framer must only start a gated tlp with a grant
  a_commit_granted: assert property (@(posedge clk_i) disable iff (rst_i)
    hdr_commit_i && (req_i.tlp_class != dll_tx_pkg::TLP_COMPLETION) |-> start_grant_o);

endmodule

/* logic/lcrc32_engine.sv */
`timescale 1ns/10ps

`include "dll_tx_defines.svh"

module lcrc32_engine (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               init_i,
  input  logic               en_i,
  input  dll_tx_pkg::dword_t data_i,
  input  logic               two_byte_i,
  output dll_tx_pkg::lcrc_t  crc_o
);

  dll_tx_pkg::lcrc_t crc_q;
  dll_tx_pkg::lcrc_t crc_base;
  dll_tx_pkg::lcrc_t crc_fold;

  assign crc_base = init_i ? `DLL_LCRC_INIT : crc_q;

  // bit serial, lane 0 first and lsb first in each byte
  always_comb begin
    crc_fold = crc_base;
    for (int i = 0; i < 32; i++) begin
      if ((i < 16) || !two_byte_i) begin
        if (crc_fold[0] ^ data_i[i]) begin
          crc_fold = (crc_fold >> 1) ^ `DLL_LCRC_POLY;
        end else begin
          crc_fold = crc_fold >> 1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      crc_q <= `DLL_LCRC_INIT;
    end else if (en_i) begin
      crc_q <= crc_fold;
    end else if (init_i) begin
      crc_q <= `DLL_LCRC_INIT;
    end
  end

  assign crc_o = crc_q;

endmodule

/* logic/seq_lcrc_framer.sv */
`timescale 1ns/10ps

module seq_lcrc_framer (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  dll_tx_pkg::dword_t     s_tdata_i,
  input  logic                   s_tlast_i,
  input  logic                   s_tvalid_i,
  output logic                   s_tready_o,
  input  logic                   start_grant_i,
  output logic                   hdr_commit_o,
  output dll_tx_pkg::tx_beat_t   out_beat_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic                   frame_done_o,
  output dll_tx_pkg::seq_num_t   tx_seq_o
);

  dll_tx_pkg::framer_state_e state_q;
  dll_tx_pkg::framer_state_e state_d;
  dll_tx_pkg::seq_num_t      seq_q;
  logic [15:0]               hold_q;
  logic                      primed_q;
  logic                      hdr_go;
  logic                      accept;
  logic                      crc_init;
  logic                      crc_en;
  logic                      crc_two;
  dll_tx_pkg::dword_t        crc_data;
  dll_tx_pkg::lcrc_t         crc;
  dll_tx_pkg::lcrc_t         lcrc;

  // crc already holds the sequence bytes of the current tlp
  assign hdr_go = start_grant_i && primed_q;
  assign accept = s_tvalid_i && s_tready_o;
  assign lcrc   = ~crc;

  always_comb begin
    state_d      = state_q;
    out_beat_o   = '0;
    out_valid_o  = 1'b0;
    s_tready_o   = 1'b0;
    hdr_commit_o = 1'b0;
    frame_done_o = 1'b0;
    crc_init     = 1'b0;
    crc_en       = 1'b0;
    crc_two      = 1'b0;
    crc_data     = s_tdata_i;

    case (state_q)
      dll_tx_pkg::ST_IDLE: begin
        out_beat_o.data = {s_tdata_i[15:0], seq_q[7:0], 4'h0, seq_q[11:8]};
        out_beat_o.keep = '1;
        out_valid_o     = s_tvalid_i && hdr_go;
        s_tready_o      = out_ready_i && hdr_go;
        if (s_tvalid_i && out_ready_i && hdr_go) begin
          hdr_commit_o = 1'b1;
          crc_en       = 1'b1;
          state_d      = s_tlast_i ? dll_tx_pkg::ST_CRC_TAIL : dll_tx_pkg::ST_STREAM;
        end else begin
          // seed with the two sequence bytes while waiting
          crc_init = 1'b1;
          crc_en   = 1'b1;
          crc_two  = 1'b1;
          crc_data = {16'h0, seq_q[7:0], 4'h0, seq_q[11:8]};
        end
      end
      dll_tx_pkg::ST_STREAM: begin
        out_beat_o.data = {s_tdata_i[15:0], hold_q};
        out_beat_o.keep = '1;
        out_valid_o     = s_tvalid_i;
        s_tready_o      = out_ready_i;
        if (s_tvalid_i && out_ready_i) begin
          crc_en = 1'b1;
          if (s_tlast_i) begin
            state_d = dll_tx_pkg::ST_CRC_TAIL;
          end
        end
      end
      dll_tx_pkg::ST_CRC_TAIL: begin
        // last two tlp bytes, then lcrc bytes 0 and 1
        out_beat_o.data = {lcrc[15:0], hold_q};
        out_beat_o.keep = '1;
        out_valid_o     = 1'b1;
        if (out_ready_i) begin
          state_d = dll_tx_pkg::ST_CRC_LAST;
        end
      end
      default: begin
        out_beat_o.data = {16'h0, lcrc[31:16]};
        out_beat_o.keep = 4'b0011;
        out_beat_o.last = 1'b1;
        out_valid_o     = 1'b1;
        if (out_ready_i) begin
          frame_done_o = 1'b1;
          state_d      = dll_tx_pkg::ST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= dll_tx_pkg::ST_IDLE;
      seq_q    <= '0;
      primed_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      primed_q <= (state_q == dll_tx_pkg::ST_IDLE) && !accept;
      if (frame_done_o) begin
        seq_q <= seq_q + 1'b1;
      end
    end
  end

  // upper half waits for the next word
  always_ff @(posedge clk_i) begin
    if (accept) begin
      hold_q <= s_tdata_i[31:16];
    end
  end

  lcrc32_engine u_lcrc (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .init_i     (crc_init),
    .en_i       (crc_en),
    .data_i     (crc_data),
    .two_byte_i (crc_two),
    .crc_o      (crc)
  );

  assign tx_seq_o = seq_q;

  // a partial beat closes the frame
  a_partial_is_last: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && (out_beat_o.keep != '1) |-> out_beat_o.last);

endmodule

/* logic/tlp_hdr_decode.sv */
`timescale 1ns/10ps

module tlp_hdr_decode (
  input  dll_tx_pkg::dword_t      hdr_i,
  output dll_tx_pkg::credit_req_t req_o
);

  logic [4:0] tlp_type;
  logic       has_data;
  logic [9:0] len_dw;
  logic [10:0] len_round;

  // fmt in byte 0 bits 7:5, fmt[1] marks a payload
  assign tlp_type = hdr_i[4:0];
  assign has_data = hdr_i[6];

  // length: byte 2 bits 1:0, then byte 3
  assign len_dw = {hdr_i[17:16], hdr_i[31:24]};

  // round up to whole 16-byte data credits
  assign len_round = {1'b0, len_dw} + 11'd3;

  always_comb begin
    req_o = '0;

    if (tlp_type == 5'b01010) begin
      req_o.tlp_class = dll_tx_pkg::TLP_COMPLETION;
    end else if ((tlp_type == 5'b00000 && has_data) || tlp_type[4:3] == 2'b10) begin
      // memory write or message
      req_o.tlp_class = dll_tx_pkg::TLP_POSTED;
    end else begin
      req_o.tlp_class = dll_tx_pkg::TLP_NON_POSTED;
    end

    req_o.hdr_need = dll_tx_pkg::hdr_cred_t'(1);

    if (has_data) begin
      req_o.data_need = dll_tx_pkg::data_cred_t'(len_round[10:2]);
    end else begin
      req_o.data_need = '0;
    end
  end

endmodule

/* logic/tx_out_skid.sv */
`timescale 1ns/10ps

module tx_out_skid (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  dll_tx_pkg::tx_beat_t in_beat_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  output dll_tx_pkg::tx_beat_t out_beat_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);

  dll_tx_pkg::tx_beat_t out_beat_q;
  dll_tx_pkg::tx_beat_t skid_beat_q;
  logic                 out_valid_q;
  logic                 skid_valid_q;
  logic                 out_free;

  // output register empties this cycle
  assign out_free   = !out_valid_q || out_ready_i;
  assign in_ready_o = !skid_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (!skid_valid_q) begin
      if (out_free) begin
        out_valid_q <= in_valid_i;
      end else if (in_valid_i) begin
        skid_valid_q <= 1'b1;
      end
    end else if (out_ready_i) begin
      // skid drains into the output register
      skid_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!skid_valid_q) begin
      if (out_free) begin
        if (in_valid_i) begin
          out_beat_q <= in_beat_i;
        end
      end else begin
        skid_beat_q <= in_beat_i;
      end
    end else if (out_ready_i) begin
      out_beat_q <= skid_beat_q;
    end
  end

  assign out_beat_o  = out_beat_q;
  assign out_valid_o = out_valid_q;

  a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_beat_o));

endmodule

/* run.sh */
#!/bin/sh
# build and run the dll tx testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f \
  --top-module dll_tx_tb -o dll_tx_sim \
  && ./obj_dir/dll_tx_sim > sim.log 2>&1 \
  || true
cat sim.log 2>/dev/null || true
grep -q "TEST PASS" sim.log 2>/dev/null && exit 0 || exit 1
